// File: hw/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Registers an instruction can name directly.
`define DEC_ARCH_REGS 16

// Physical register file size including all banked copies.
`define DEC_PHY_REGS 31

// Width of a physical register index.
`define DEC_PHY_W 5

// PC-plus-8 value presented after reset or a flush.
`define DEC_RESET_PC 32'd8

`endif

// File: hw/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

        // Processor modes as encoded in CPSR bits 4:0.
        typedef enum logic [4:0] {
                MODE_USR = 5'h10,
                MODE_FIQ = 5'h11,
                MODE_IRQ = 5'h12,
                MODE_SVC = 5'h13,
                MODE_ABT = 5'h17,
                MODE_UND = 5'h1B,
                MODE_SYS = 5'h1F
        } cpu_mode_e;

        typedef enum logic [2:0] {
                CLS_NONE,
                CLS_DATA,
                CLS_LOAD,
                CLS_STORE,
                CLS_BRANCH,
                CLS_SWI,
                CLS_UND
        } instr_class_e;

        // Data-processing opcodes in architectural order.
        typedef enum logic [3:0] {
                ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
                ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
                ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
                ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
        } alu_op_e;

        typedef enum logic [3:0] {
                COND_EQ, COND_NE, COND_CS, COND_CC,
                COND_MI, COND_PL, COND_VS, COND_VC,
                COND_HI, COND_LS, COND_GE, COND_LT,
                COND_GT, COND_LE, COND_AL, COND_NV
        } cond_e;

        typedef logic [`DEC_PHY_W-1:0] phy_idx_t;

        typedef struct packed {
                cond_e          cond;
                instr_class_e   cls;
                alu_op_e        alu_op;
                logic           flag_update;
                logic           use_imm;
                logic [31:0]    imm;
        } field_dec_t;

        typedef struct packed {
                phy_idx_t       rn;
                phy_idx_t       rd;
                phy_idx_t       rm;
        } bank_idx_t;

        typedef struct packed {
                logic           valid;
                field_dec_t     fields;
                bank_idx_t      idx;
                logic           irq;
                logic           fiq;
                logic [31:0]    pc_plus_8;
        } decoded_uop_t;

endpackage

// File: hw/decode_fields.sv
module decode_fields
        import decode_pkg::*;
(
        input  logic [31:0]     i_instr,
        output field_dec_t      o_fields
);

        logic   is_swi;
        logic   is_branch;
        logic   is_mem;
        logic   is_data;

        // Instruction group from the upper opcode bits.
        assign is_swi    = &i_instr[27:24];
        assign is_branch = (i_instr[27:25] == 3'b101);
        assign is_mem    = (i_instr[27:26] == 2'b01);
        assign is_data   = (i_instr[27:26] == 2'b00);

        always_comb
        begin
                // Defaults describe an undefined instruction.
                o_fields.cond        = cond_e'(i_instr[31:28]);
                o_fields.cls         = CLS_UND;
                o_fields.alu_op      = ALU_AND;
                o_fields.flag_update = 1'b0;
                o_fields.use_imm     = 1'b0;
                o_fields.imm         = 32'd0;

                if (is_swi)
                begin
                        o_fields.cls = CLS_SWI;
                end
                else if (is_branch)
                begin
                        // Word offset, sign extended, scaled to bytes.
                        o_fields.cls     = CLS_BRANCH;
                        o_fields.use_imm = 1'b1;
                        o_fields.imm     = {{6{i_instr[23]}}, i_instr[23:0], 2'b00};
                end
                else if (is_mem)
                begin
                        // Register offset with bit 4 set is not a transfer.
                        if (i_instr[25] && i_instr[4])
                        begin
                                o_fields.cls = CLS_UND;
                        end
                        else
                        begin
                                o_fields.cls = i_instr[20] ? CLS_LOAD : CLS_STORE;
                                if (!i_instr[25])
                                begin
                                        o_fields.use_imm = 1'b1;
                                        o_fields.imm     = {20'd0, i_instr[11:0]};
                                end
                        end
                end
                else if (is_data)
                begin
                        o_fields.cls         = CLS_DATA;
                        o_fields.alu_op      = alu_op_e'(i_instr[24:21]);
                        o_fields.flag_update = i_instr[20];
                        // Rotation of the 8-bit immediate happens later.
                        if (i_instr[25])
                        begin
                                o_fields.use_imm = 1'b1;
                                o_fields.imm     = {24'd0, i_instr[7:0]};
                        end
                end
        end

endmodule

// File: hw/bank_map.sv
`include "decode_params.svh"

module bank_map
        import decode_pkg::*;
(
        input  logic [31:0]     i_instr,
        input  cpu_mode_e       i_mode,
        output bank_idx_t       o_idx
);

        localparam int ARCH_W = $clog2(`DEC_ARCH_REGS);

        // Base of each r13/r14 pair; the FIQ r8-r12 copies sit just below.
        localparam phy_idx_t FIQ_HI = phy_idx_t'(`DEC_ARCH_REGS + 5);
        localparam phy_idx_t IRQ_HI = FIQ_HI + phy_idx_t'(2);
        localparam phy_idx_t SVC_HI = IRQ_HI + phy_idx_t'(2);
        localparam phy_idx_t ABT_HI = SVC_HI + phy_idx_t'(2);
        localparam phy_idx_t UND_HI = phy_idx_t'(`DEC_PHY_REGS - 2);

        logic [ARCH_W-1:0]      rn_f;
        logic [ARCH_W-1:0]      rd_f;
        logic [ARCH_W-1:0]      rm_f;

        function automatic phy_idx_t map_reg(input logic [ARCH_W-1:0] r, input cpu_mode_e mode);
                phy_idx_t base;
                base    = phy_idx_t'(r);
                map_reg = phy_idx_t'(r);
                if (r >= 4'd8 && r <= 4'd12 && mode == MODE_FIQ)
                        map_reg = phy_idx_t'(`DEC_ARCH_REGS) + phy_idx_t'(r - 4'd8);
                else if (r == 4'd13 || r == 4'd14)
                begin
                        case (mode)
                        MODE_FIQ: base = FIQ_HI;
                        MODE_IRQ: base = IRQ_HI;
                        MODE_SVC: base = SVC_HI;
                        MODE_ABT: base = ABT_HI;
                        MODE_UND: base = UND_HI;
                        default:  base = phy_idx_t'(4'd13);
                        endcase
                        map_reg = base + phy_idx_t'(r == 4'd14);
                end
        endfunction

        assign rn_f = i_instr[19:16];
        assign rd_f = i_instr[15:12];
        assign rm_f = i_instr[3:0];

        assign o_idx.rn = map_reg(rn_f, i_mode);
        assign o_idx.rd = map_reg(rd_f, i_mode);
        assign o_idx.rm = map_reg(rm_f, i_mode);

endmodule

// File: hw/decode_pipe_reg.sv
`include "decode_params.svh"

module decode_pipe_reg
        import decode_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_clear,
        input  logic            i_stall,
        input  logic            i_valid,
        input  field_dec_t      i_fields,
        input  bank_idx_t       i_idx,
        input  logic [31:0]     i_pc_plus_8,
        input  logic [31:0]     i_cpsr,
        input  logic            i_irq,
        input  logic            i_fiq,
        output decoded_uop_t    o_uop
);

        // CPSR interrupt mask bits.
        localparam int I_BIT = 7;
        localparam int F_BIT = 6;

        decoded_uop_t   clr_uop;
        decoded_uop_t   nxt_uop;

        // Empty slot seen after reset or a flush.
        always_comb
        begin
                clr_uop                  = '0;
                clr_uop.fields.cls       = CLS_NONE;
                clr_uop.fields.cond      = COND_NV;
                clr_uop.pc_plus_8        = `DEC_RESET_PC;
        end

        always_comb
        begin
                nxt_uop.valid     = i_valid;
                nxt_uop.fields    = i_fields;
                nxt_uop.idx       = i_idx;
                nxt_uop.pc_plus_8 = i_pc_plus_8;
                // Interrupts travel even in a bubble.
                nxt_uop.irq       = i_irq & ~i_cpsr[I_BIT];
                nxt_uop.fiq       = i_fiq & ~i_cpsr[F_BIT];
                if (!i_valid)
                begin
                        nxt_uop.fields.cls  = CLS_NONE;
                        nxt_uop.fields.cond = COND_NV;
                end
        end

        // Clear beats stall and stall holds the slot.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        o_uop <= clr_uop;
                end
                else if (!i_stall)
                begin
                        o_uop <= nxt_uop;
                end
        end

endmodule

// File: hw/decode_top.sv
module decode_top
        import decode_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_clear,
        input  logic            i_stall,
        input  logic            i_valid,
        input  logic [31:0]     i_instr,
        input  logic [31:0]     i_pc_plus_8,
        input  logic [31:0]     i_cpsr,
        input  logic            i_irq,
        input  logic            i_fiq,
        output decoded_uop_t    o_uop
);

        field_dec_t     fields;
        bank_idx_t      idx;

        decode_fields u_fields (
                .i_instr        (i_instr),
                .o_fields       (fields)
        );

        // Mode field of the CPSR selects the register bank.
        bank_map u_bank (
                .i_instr        (i_instr),
                .i_mode         (cpu_mode_e'(i_cpsr[4:0])),
                .o_idx          (idx)
        );

        decode_pipe_reg u_reg (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_clear        (i_clear),
                .i_stall        (i_stall),
                .i_valid        (i_valid),
                .i_fields       (fields),
                .i_idx          (idx),
                .i_pc_plus_8    (i_pc_plus_8),
                .i_cpsr         (i_cpsr),
                .i_irq          (i_irq),
                .i_fiq          (i_fiq),
                .o_uop          (o_uop)
        );

endmodule

// File: bench/decode_tb.sv
`include "decode_params.svh"

module decode_tb
        import decode_pkg::*;
();

        localparam int VEC_W        = 13;
        localparam int NUM_VEC      = 20;
        localparam int NUM_RAND     = 64;
        localparam int RESET_CYCLES = 4;
        localparam int CYCLE_LIMIT  = 4 * (RESET_CYCLES + NUM_VEC + NUM_RAND);

        logic           i_clk;
        logic           i_reset;
        logic           i_clear;
        logic           i_stall;
        logic           i_valid;
        logic           i_irq;
        logic           i_fiq;
        logic [31:0]    i_instr;
        logic [31:0]    i_pc_plus_8;
        logic [31:0]    i_cpsr;
        decoded_uop_t   o_uop;

        logic [31:0]    vec_mem [0:NUM_VEC*VEC_W-1];
        logic [4:0]     mode_tab [0:7];
        logic [31:0]    rng_state;
        logic [31:0]    rnd_instr;
        logic [4:0]     rnd_mode;
        bank_idx_t      exp_idx;
        int             checks;
        int             errors;
        int             cycles;
        int             c0;
        int             e0;
        int             k;

        decode_top UUT (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_clear        (i_clear),
                .i_stall        (i_stall),
                .i_valid        (i_valid),
                .i_instr        (i_instr),
                .i_pc_plus_8    (i_pc_plus_8),
                .i_cpsr         (i_cpsr),
                .i_irq          (i_irq),
                .i_fiq          (i_fiq),
                .o_uop          (o_uop)
        );

        always #50 i_clk = ~i_clk;

        always @(posedge i_clk)
        begin
                cycles = cycles + 1;
                if (cycles >= CYCLE_LIMIT)
                begin
                        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("test failed");
                        $finish;
                end
        end

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1103515245 + 32'd12345;
        endfunction

        // Banked copies sit at a fixed distance above the architectural number.
        function automatic phy_idx_t bank_of(input logic [3:0] r, input logic [4:0] mode);
                logic           sp_lr;
                logic           fiq_hi;
                phy_idx_t       shift;
                sp_lr  = (r == 4'd13) || (r == 4'd14);
                fiq_hi = (r >= 4'd8) && (r <= 4'd14);
                case (mode)
                MODE_FIQ: shift = fiq_hi ? 5'd8 : 5'd0;
                MODE_IRQ: shift = sp_lr ? 5'd10 : 5'd0;
                MODE_SVC: shift = sp_lr ? 5'd12 : 5'd0;
                MODE_ABT: shift = sp_lr ? 5'd14 : 5'd0;
                MODE_UND: shift = sp_lr ? 5'd16 : 5'd0;
                default:  shift = 5'd0;
                endcase
                return {1'b0, r} + shift;
        endfunction

        function automatic field_dec_t cleared_fields();
                field_dec_t f;
                f      = '0;
                f.cls  = CLS_NONE;
                f.cond = COND_NV;
                return f;
        endfunction

        task automatic check_fields(input field_dec_t got, input field_dec_t exp, input string tag);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("FAIL %0t: %s fields got %h, expected %h", $time, tag, got, exp);
                end
        endtask

        task automatic check_idx(input bank_idx_t got, input bank_idx_t exp, input string tag);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("FAIL %0t: %s rn/rd/rm got %0d/%0d/%0d, expected %0d/%0d/%0d",
                                 $time, tag, got.rn, got.rd, got.rm, exp.rn, exp.rd, exp.rm);
                end
        endtask

        task automatic check_ctrl(input logic v, input logic irq, input logic fiq,
                                  input logic [31:0] pc, input logic exp_v, input logic exp_irq,
                                  input logic exp_fiq, input logic [31:0] exp_pc, input string tag);
                checks++;
                if ({v, irq, fiq, pc} !== {exp_v, exp_irq, exp_fiq, exp_pc})
                begin
                        errors++;
                        $display("FAIL %0t: %s valid/irq/fiq/pc got %b%b%b %h, expected %b%b%b %h",
                                 $time, tag, v, irq, fiq, pc, exp_v, exp_irq, exp_fiq, exp_pc);
                end
        endtask

        // Inputs change and outputs are read 5 units after the edge.
        task automatic tick();
                @(posedge i_clk);
                #5;
        endtask

        task automatic apply_vec(input int n, input logic hold);
                logic [31:0] ctrl;
                ctrl        = vec_mem[n * VEC_W + 3];
                i_instr     = vec_mem[n * VEC_W];
                i_cpsr      = vec_mem[n * VEC_W + 1];
                i_pc_plus_8 = vec_mem[n * VEC_W + 2];
                i_valid     = ctrl[4];
                i_stall     = ctrl[3] | hold;
                i_clear     = ctrl[2];
                i_irq       = ctrl[1];
                i_fiq       = ctrl[0];
        endtask

        // A row with clear set expects the empty micro-op in its expected columns.
        task automatic check_vec(input int n, input string tag);
                int             b;
                logic [31:0]    ctrl;
                logic [31:0]    cpsr;
                field_dec_t     exp_f;
                bank_idx_t      exp_i;
                b                 = n * VEC_W;
                ctrl              = vec_mem[b + 3];
                cpsr              = vec_mem[b + 1];
                exp_f.cls         = instr_class_e'(vec_mem[b + 4][2:0]);
                exp_f.alu_op      = alu_op_e'(vec_mem[b + 5][3:0]);
                exp_f.cond        = cond_e'(vec_mem[b + 6][3:0]);
                exp_f.flag_update = vec_mem[b + 7][0];
                exp_f.use_imm     = vec_mem[b + 8][0];
                exp_f.imm         = vec_mem[b + 9];
                exp_i.rn          = vec_mem[b + 10][4:0];
                exp_i.rd          = vec_mem[b + 11][4:0];
                exp_i.rm          = vec_mem[b + 12][4:0];
                check_fields(o_uop.fields, exp_f, tag);
                check_idx(o_uop.idx, exp_i, tag);
                if (ctrl[2])
                        check_ctrl(o_uop.valid, o_uop.irq, o_uop.fiq, o_uop.pc_plus_8,
                                   1'b0, 1'b0, 1'b0, `DEC_RESET_PC, tag);
                else
                        check_ctrl(o_uop.valid, o_uop.irq, o_uop.fiq, o_uop.pc_plus_8,
                                   ctrl[4], ctrl[1] & ~cpsr[7], ctrl[0] & ~cpsr[6],
                                   vec_mem[b + 2], tag);
        endtask

        task automatic finish_test(input string name);
                $display("%s: %0d checks, %0d mismatches", name, checks - c0, errors - e0);
                c0 = checks;
                e0 = errors;
        endtask

        initial
        begin
                i_clk       = 1'b0;
                i_reset     = 1'b1;
                i_clear     = 1'b0;
                i_stall     = 1'b0;
                i_valid     = 1'b0;
                i_irq       = 1'b0;
                i_fiq       = 1'b0;
                i_instr     = 32'd0;
                i_pc_plus_8 = 32'd0;
                i_cpsr      = 32'h10;
                checks      = 0;
                errors      = 0;
                cycles      = 0;
                c0          = 0;
                e0          = 0;
                rng_state   = 32'd377;
                mode_tab[0] = MODE_USR;
                mode_tab[1] = MODE_FIQ;
                mode_tab[2] = MODE_IRQ;
                mode_tab[3] = MODE_SVC;
                mode_tab[4] = MODE_ABT;
                mode_tab[5] = MODE_UND;
                mode_tab[6] = MODE_SYS;
                // Illegal mode value that takes the unbanked mapping.
                mode_tab[7] = 5'h00;
                $readmemh("bench/decode_input.dat", vec_mem);
                if ($isunknown(vec_mem[0]))
                begin
                        errors++;
                        $display("vector file bench/decode_input.dat could not be read");
                end

                repeat (RESET_CYCLES) @(posedge i_clk);
                #5;
                i_reset = 1'b0;
                check_fields(o_uop.fields, cleared_fields(), "reset");
                check_idx(o_uop.idx, '0, "reset");
                check_ctrl(o_uop.valid, o_uop.irq, o_uop.fiq, o_uop.pc_plus_8,
                           1'b0, 1'b0, 1'b0, `DEC_RESET_PC, "reset");
                finish_test("reset");

                for (k = 0; k < NUM_VEC; k++)
                begin
                        apply_vec(k, 1'b0);
                        tick();
                        check_vec(k, $sformatf("vector %0d", k));
                end
                finish_test("vectors");

                // Rows 1 to 3 are presented under stall and must not show up.
                apply_vec(0, 1'b0);
                tick();
                check_vec(0, "stall base");
                for (k = 1; k < 4; k++)
                begin
                        apply_vec(k, 1'b1);
                        tick();
                        check_vec(0, $sformatf("stall hold %0d", k));
                end
                apply_vec(7, 1'b0);
                tick();
                check_vec(7, "stall release");
                finish_test("stall");

                for (k = 0; k < NUM_RAND; k++)
                begin
                        rng_state   = lcg_next(rng_state);
                        rnd_instr   = rng_state;
                        rng_state   = lcg_next(rng_state);
                        rnd_mode    = mode_tab[rng_state[30:28]];
                        i_instr     = rnd_instr;
                        i_cpsr      = {27'd0, rnd_mode};
                        i_pc_plus_8 = 32'h2000 + 32'(k * 4);
                        i_valid     = 1'b1;
                        i_stall     = 1'b0;
                        i_clear     = 1'b0;
                        i_irq       = 1'b0;
                        i_fiq       = 1'b0;
                        tick();
                        exp_idx.rn = bank_of(rnd_instr[19:16], rnd_mode);
                        exp_idx.rd = bank_of(rnd_instr[15:12], rnd_mode);
                        exp_idx.rm = bank_of(rnd_instr[3:0], rnd_mode);
                        check_idx(o_uop.idx, exp_idx, $sformatf("random %0d mode %h", k, rnd_mode));
                        check_ctrl(o_uop.valid, o_uop.irq, o_uop.fiq, o_uop.pc_plus_8,
                                   1'b1, 1'b0, 1'b0, 32'h2000 + 32'(k * 4), "random");
                end
                finish_test("random banking");

                $display("summary: %0d checks, %0d errors", checks, errors);
                if (errors == 0)
                begin
                        $display("test passed");
                end
                else
                begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

// File: bench/decode_input.dat
// instr cpsr pc ctrl(valid,stall,clear,irq,fiq as bits 4..0)
// expected: cls alu_op cond flag_update use_imm imm rn rd rm
E2921045 00000010 00001008 10 1 4 E 1 1 00000045 02 01 05
01A03004 00000010 0000100C 10 1 D 0 0 0 00000000 00 03 04
E158900A 00000011 00001010 10 1 A E 1 0 00000000 10 11 12
E59CB123 00000011 00001014 10 2 0 E 0 1 00000123 14 13 03
E58EDFFF 00000012 00001018 10 3 0 E 0 1 00000FFF 18 17 0F
E79D000E 00000013 0000101C 10 2 0 E 0 0 00000000 19 00 1A
E79D001E 00000017 00001020 10 6 0 E 0 0 00000000 1B 00 1C
EA000010 0000001B 00001024 10 4 0 E 0 1 00000040 00 00 00
0BFFFFFE 0000001B 00001028 10 4 0 0 0 1 FFFFFFF8 0F 0F 1E
EF000011 0000001F 0000102C 10 5 0 E 0 0 00000000 00 00 01
EE012F10 00000010 00001030 10 6 0 E 0 0 00000000 01 02 00
E008C00E 00000012 00001034 10 1 0 E 0 0 00000000 08 0C 18
E009D00E 00000013 00001038 10 1 0 E 0 0 00000000 09 19 1A
E00AE00D 00000017 0000103C 10 1 0 E 0 0 00000000 0A 1C 1B
E00BD008 0000001B 00001040 10 1 0 E 0 0 00000000 0B 1D 08
E00DE00B 00000011 00001044 10 1 0 E 0 0 00000000 15 16 13
E00DE00B 00000010 00001048 03 0 0 F 0 0 00000000 0D 0E 0B
01A03004 00000090 0000104C 13 1 D 0 0 0 00000000 00 03 04
EF000011 00000050 00001050 13 5 0 E 0 0 00000000 00 00 01
E2921045 00000010 00001054 1F 0 0 F 0 0 00000000 00 00 00

// File: flist.f
+incdir+hw
hw/decode_pkg.sv
hw/decode_fields.sv
hw/bank_map.sv
hw/decode_pipe_reg.sv
hw/decode_top.sv
bench/decode_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f flist.f --top-module decode_tb -Mdir obj_dir -o decode_sim

run: build
	./obj_dir/decode_sim | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	verilator --lint-only -Wall -Ihw hw/decode_pkg.sv hw/decode_fields.sv hw/bank_map.sv \
		hw/decode_pipe_reg.sv hw/decode_top.sv --top-module decode_top

clean:
	rm -rf obj_dir $(LOG)
